//--- Bender.yml
package:
  name: lmg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/lmg_pkg.sv
      - rtl/square_targets.sv
      - rtl/move_serializer.sv
      - rtl/move_fifo.sv
      - rtl/lmg_ctrl.sv
      - rtl/lmg.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/lmg_clk_gen.sv
      - tests/lmg_chk.sv
      - tests/lmg_tb.sv

//--- compile.f
+incdir+include
rtl/lmg_pkg.sv
rtl/square_targets.sv
rtl/move_serializer.sv
rtl/move_fifo.sv
rtl/lmg_ctrl.sv
rtl/lmg.sv
tests/lmg_clk_gen.sv
tests/lmg_chk.sv
tests/lmg_tb.sv

//--- include/lmg_settings.svh
`ifndef LMG_SETTINGS_SVH
`define LMG_SETTINGS_SVH

// board geometry
`define LMG_NUM_SQUARES 64
`define LMG_SQ_BITS 4
`define LMG_IDX_BITS 6

// colour bit inside a square nibble, 1 is black
`define LMG_COLOR_BIT 3

// piece codes in bits 2..0 of a square
`define LMG_PIECE_EMPTY 3'd0
`define LMG_PIECE_KNIGHT 3'd2
`define LMG_PIECE_KING 3'd6

// output fifo
`define LMG_FIFO_DEPTH 64

`endif

//--- rtl/lmg.sv
`timescale 1ns/1ps

module lmg import lmg_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  board_t bstate,
	input  logic   side,
	input  logic   rden,
	output move_t  fifo_out,
	output logic   empty,
	output logic   done
);

	board_t board_q;
	logic side_q;
	sq_idx_t sq_ptr;
	sq_mask_t tgt_mask;
	sq_mask_t cap_mask;
	logic load;
	logic finished;
	logic wr_en;
	move_t move;
	logic full;

	lmg_ctrl ctrl0 (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.bstate   (bstate),
		.side     (side),
		.tgt_mask (tgt_mask),
		.finished (finished),
		.board_q  (board_q),
		.side_q   (side_q),
		.sq_ptr   (sq_ptr),
		.load     (load),
		.done     (done)
	);

	square_targets targets0 (
		.board    (board_q),
		.side     (side_q),
		.sq       (sq_ptr),
		.tgt_mask (tgt_mask),
		.cap_mask (cap_mask)
	);

	move_serializer ser0 (
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.from_sq  (sq_ptr),
		.tgt_mask (tgt_mask),
		.cap_mask (cap_mask),
		.full     (full),
		.wr_en    (wr_en),
		.move     (move),
		.finished (finished)
	);

	move_fifo fifo0 (
		.clk   (clk),
		.reset (reset),
		.wr_en (wr_en),
		.wdata (move),
		.rd_en (rden),
		.rdata (fifo_out),
		.full  (full),
		.empty (empty)
	);

endmodule

//--- rtl/lmg_ctrl.sv
`timescale 1ns/1ps
`include "lmg_settings.svh"

module lmg_ctrl import lmg_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  board_t   bstate,
	input  logic     side,
	input  sq_mask_t tgt_mask,
	input  logic     finished,
	output board_t   board_q,
	output logic     side_q,
	output sq_idx_t  sq_ptr,
	output logic     load,
	output logic     done
);

	ctrl_state_t state;
	logic accept;
	logic last_sq;

	// start only counts between scans
	assign accept = start && (state == IDLE || state == FIN);
	assign last_sq = sq_ptr == sq_idx_t'(`LMG_NUM_SQUARES - 1);

	// hand a square with targets to the serializer
	assign load = (state == SCAN) && (tgt_mask != '0);

	assign done = state == FIN;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			sq_ptr <= '0;
		end else begin
			case (state)
				IDLE, FIN: begin
					if (accept) begin
						state <= SCAN;
						sq_ptr <= '0;
					end
				end
				SCAN: begin
					if (load) begin
						state <= EMIT;
					end else if (last_sq) begin
						state <= FIN;
					end else begin
						sq_ptr <= sq_ptr + 1'b1;
					end
				end
				EMIT: begin
					// held here through fifo stalls
					if (finished) begin
						if (last_sq) begin
							state <= FIN;
						end else begin
							state <= SCAN;
							sq_ptr <= sq_ptr + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// board snapshot for the whole scan
	always_ff @(posedge clk) begin
		if (accept) begin
			board_q <= bstate;
			side_q <= side;
		end
	end

endmodule

//--- rtl/lmg_pkg.sv
`include "lmg_settings.svh"

package lmg_pkg;

	// whole board, square i at bits 4i+3..4i
	typedef logic [`LMG_NUM_SQUARES*`LMG_SQ_BITS-1:0] board_t;

	// colour bit and piece code of one square
	typedef logic [`LMG_SQ_BITS-1:0] square_t;

	typedef logic [`LMG_IDX_BITS-1:0] sq_idx_t;

	// one bit per square
	typedef logic [`LMG_NUM_SQUARES-1:0] sq_mask_t;

	// {capture, from, to}
	typedef logic [2*`LMG_IDX_BITS:0] move_t;

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		EMIT,
		FIN
	} ctrl_state_t;

endpackage

//--- rtl/move_fifo.sv
`timescale 1ns/1ps
`include "lmg_settings.svh"

module move_fifo import lmg_pkg::*; #(
	parameter int DEPTH = `LMG_FIFO_DEPTH
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  wr_en,
	input  move_t wdata,
	input  logic  rd_en,
	output move_t rdata,
	output logic  full,
	output logic  empty
);

	localparam int PTR_W = $clog2(DEPTH);

	move_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full = count == (PTR_W+1)'(DEPTH);
	assign empty = count == '0;

	// show-ahead head
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/move_serializer.sv
`timescale 1ns/1ps
`include "lmg_settings.svh"

module move_serializer import lmg_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     load,
	input  sq_idx_t  from_sq,
	input  sq_mask_t tgt_mask,
	input  sq_mask_t cap_mask,
	input  logic     full,
	output logic     wr_en,
	output move_t    move,
	output logic     finished
);

	sq_idx_t from_q;
	sq_mask_t tgt_q;
	sq_mask_t cap_q;
	sq_mask_t rest;
	sq_idx_t idx;

	// lowest remaining target wins
	always_comb begin
		idx = '0;
		for (int i = `LMG_NUM_SQUARES - 1; i >= 0; i--) begin
			if (tgt_q[i]) begin
				idx = sq_idx_t'(i);
			end
		end
	end

	// mask with the lowest set bit cleared
	assign rest = tgt_q & (tgt_q - 1'b1);

	// a stalled write just waits, nothing advances
	assign wr_en = (tgt_q != '0) && !full;
	assign move = {cap_q[idx], from_q, idx};
	assign finished = wr_en && (rest == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			tgt_q <= '0;
		end else if (load) begin
			tgt_q <= tgt_mask;
		end else if (wr_en) begin
			tgt_q <= rest;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			from_q <= from_sq;
			cap_q <= cap_mask;
		end
	end

endmodule

//--- rtl/square_targets.sv
`timescale 1ns/1ps
`include "lmg_settings.svh"

module square_targets import lmg_pkg::*; (
	input  board_t   board,
	input  logic     side,
	input  sq_idx_t  sq,
	output sq_mask_t tgt_mask,
	output sq_mask_t cap_mask
);

	// steps as (file, rank) pairs
	localparam int KNIGHT_DF [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
	localparam int KNIGHT_DR [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
	localparam int KING_DF [8] = '{1, 1, 0, -1, -1, -1, 0, 1};
	localparam int KING_DR [8] = '{0, 1, 1, 1, 0, -1, -1, -1};

	square_t from_sq;
	logic is_knight;
	logic is_king;
	logic active;

	assign from_sq = board[sq * `LMG_SQ_BITS +: `LMG_SQ_BITS];
	assign is_knight = from_sq[2:0] == `LMG_PIECE_KNIGHT;
	assign is_king = from_sq[2:0] == `LMG_PIECE_KING;

	// only pieces of the side to move produce targets
	assign active = (is_knight || is_king) && (from_sq[`LMG_COLOR_BIT] == side);

	always_comb begin
		int nf;
		int nr;
		int t;
		square_t dst;

		tgt_mask = '0;
		cap_mask = '0;
		nf = 0;
		nr = 0;
		t = 0;
		dst = '0;
		for (int k = 0; k < 8; k++) begin
			// file is sq mod 8, rank is sq div 8
			if (is_knight) begin
				nf = int'(sq[2:0]) + KNIGHT_DF[k];
				nr = int'(sq[5:3]) + KNIGHT_DR[k];
			end else begin
				nf = int'(sq[2:0]) + KING_DF[k];
				nr = int'(sq[5:3]) + KING_DR[k];
			end

			// file bounds catch the edge wrap
			if (active && nf >= 0 && nf < 8 && nr >= 0 && nr < 8) begin
				t = nr * 8 + nf;
				dst = board[t * `LMG_SQ_BITS +: `LMG_SQ_BITS];
				if (dst[2:0] == `LMG_PIECE_EMPTY) begin
					tgt_mask[t] = 1'b1;
				end else if (dst[`LMG_COLOR_BIT] != side) begin
					tgt_mask[t] = 1'b1;
					cap_mask[t] = 1'b1;
				end
			end
		end
	end

endmodule

//--- tests/lmg_chk.sv
`timescale 1ns/1ps

module lmg_chk import lmg_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  load,
	input logic  ser_idle,
	input logic  wr_en,
	input logic  full,
	input move_t move,
	input logic  write_pending,
	input logic  done
);

	int fails = 0;

	// a new square only once the previous one is written out
	a_load_when_idle: assert property (@(posedge clk) disable iff (reset) load |-> ser_idle)
	else begin
		fails++;
		$error("load arrived while the serializer still held targets");
	end

	// a stalled move waits unchanged for room in the FIFO
	a_hold_on_full: assert property (@(posedge clk) disable iff (reset)
		write_pending && full |=> $stable(move))
	else begin
		fails++;
		$error("move changed while the FIFO was full");
	end

	// a piece never moves onto its own square
	a_from_not_to: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> move[11:6] != move[5:0])
	else begin
		fails++;
		$error("move with equal from and to squares");
	end

	a_no_done_while_writing: assert property (@(posedge clk) disable iff (reset)
		write_pending |-> !done)
	else begin
		fails++;
		$error("done was high while the serializer was still writing moves");
	end

endmodule

bind lmg_ctrl lmg_chk ctrl_chk0 (
	.clk           (clk),
	.reset         (reset),
	.load          (1'b0),
	.ser_idle      (1'b1),
	.wr_en         (1'b0),
	.full          (1'b0),
	.move          ('0),
	.write_pending (finished),
	.done          (done)
);

bind move_serializer lmg_chk ser_chk0 (
	.clk           (clk),
	.reset         (reset),
	.load          (load),
	.ser_idle      (tgt_q == '0),
	.wr_en         (wr_en),
	.full          (full),
	.move          (move),
	.write_pending (tgt_q != '0),
	.done          (1'b0)
);

//--- tests/lmg_clk_gen.sv
`timescale 1ns/1ps

module lmg_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

//--- tests/lmg_tb.sv
`timescale 1ns/1ps

module lmg_tb import lmg_pkg::*; ();

	localparam int NUM_ENTRIES = 6;
	localparam int MAX_MOVES = 32;
	localparam int CYCLES_PER_PASS = 64 + 4 * MAX_MOVES + 20;

	// square nibbles, bit 3 set for black
	localparam logic [3:0] W_PAWN = 4'h1;
	localparam logic [3:0] W_KNIGHT = 4'h2;
	localparam logic [3:0] W_ROOK = 4'h4;
	localparam logic [3:0] W_KING = 4'h6;
	localparam logic [3:0] B_PAWN = 4'h9;
	localparam logic [3:0] B_KNIGHT = 4'hA;
	localparam logic [3:0] B_BISHOP = 4'hB;
	localparam logic [3:0] B_ROOK = 4'hC;
	localparam logic [3:0] B_QUEEN = 4'hD;
	localparam logic [3:0] B_KING = 4'hE;

	logic clk;
	logic reset;
	logic start;
	board_t bstate;
	logic side;
	logic rden;
	move_t fifo_out;
	logic empty;
	logic done;

	board_t boards [NUM_ENTRIES];
	logic sides [NUM_ENTRIES];
	int passes [NUM_ENTRIES];
	int counts [NUM_ENTRIES];
	move_t exp_moves [NUM_ENTRIES][MAX_MOVES];
	int tos [$];
	int value_errors;
	int missing_errors;
	int extra_errors;
	int other_errors;
	logic table_ready;
	logic scan_over;

	lmg_clk_gen clk_gen0 (
		.clk   (clk),
		.reset (reset)
	);

	lmg dut0 (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.bstate   (bstate),
		.side     (side),
		.rden     (rden),
		.fifo_out (fifo_out),
		.empty    (empty),
		.done     (done)
	);

	function automatic void put_piece(int e, int sq, logic [3:0] piece);
		boards[e][sq*4 +: 4] = piece;
	endfunction

	// targets in tos, already ascending; an occupied target is an opponent capture
	function automatic void add_moves(int e, int from);
		logic cap;
		foreach (tos[k]) begin
			cap = boards[e][tos[k]*4 +: 3] != 3'd0;
			exp_moves[e][counts[e]] = {cap, 6'(from), 6'(tos[k])};
			counts[e]++;
		end
	endfunction

	task automatic check_flag(input string name, input logic got, input logic want);
		assert (got === want) else begin
			value_errors++;
			$display("ERROR %s expected %h actual %h", name, want, got);
		end
	endtask

	task automatic build_table();
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			boards[e] = '0;
			sides[e] = 1'b0;
			passes[e] = 1;
			counts[e] = 0;
		end
		// entry 0 stays an empty board
		put_piece(1, 0, W_KNIGHT);
		tos = {10, 17};
		add_moves(1, 0);
		// file h pieces, nothing may wrap to file a
		put_piece(2, 7, W_KNIGHT);
		put_piece(2, 31, W_KING);
		tos = {13, 22};
		add_moves(2, 7);
		tos = {22, 23, 30, 38, 39};
		add_moves(2, 31);
		// central king among own and black pieces
		put_piece(3, 28, W_KING);
		put_piece(3, 20, W_PAWN);
		put_piece(3, 27, W_ROOK);
		put_piece(3, 21, B_PAWN);
		put_piece(3, 36, B_KNIGHT);
		tos = {19, 21, 29, 35, 36};
		tos.push_back(37);
		add_moves(3, 28);
		// black to move with no knight or king of its own
		sides[4] = 1'b1;
		put_piece(4, 12, W_KNIGHT);
		put_piece(4, 50, B_PAWN);
		put_piece(4, 56, B_ROOK);
		put_piece(4, 58, B_BISHOP);
		put_piece(4, 59, B_QUEEN);
		// busy board scanned four times so the FIFO overflows into stalls
		sides[5] = 1'b1;
		passes[5] = 4;
		put_piece(5, 8, B_KNIGHT);
		put_piece(5, 35, B_KNIGHT);
		put_piece(5, 57, B_KNIGHT);
		put_piece(5, 60, B_KING);
		put_piece(5, 62, B_KNIGHT);
		put_piece(5, 51, B_PAWN);
		put_piece(5, 61, B_BISHOP);
		put_piece(5, 2, W_KING);
		put_piece(5, 20, W_PAWN);
		put_piece(5, 42, W_KNIGHT);
		put_piece(5, 52, W_ROOK);
		tos = {2, 18, 25};
		add_moves(5, 8);
		tos = {18, 20, 25, 29, 41, 45, 50, 52};
		add_moves(5, 35);
		tos = {40, 42};
		add_moves(5, 57);
		tos = {52, 53, 59};
		add_moves(5, 60);
		tos = {45, 47, 52};
		add_moves(5, 62);
	endtask

	task automatic run_scans(input int e);
		for (int p = 0; p < passes[e]; p++) begin
			@(posedge clk);
			#1;
			bstate = boards[e];
			side = sides[e];
			start = 1'b1;
			@(posedge clk);
			#1;
			start = 1'b0;
			check_flag("done", done, 1'b0);
			while (done !== 1'b1) begin
				@(posedge clk);
				#1;
			end
		end
		scan_over = 1'b1;
	endtask

	task automatic read_moves(input int e);
		int idx;
		int gap;
		int total;
		move_t want;
		idx = 0;
		gap = 0;
		total = counts[e] * passes[e];
		// repeated scans wait for the FIFO to fill before reading
		if (passes[e] > 1) begin
			while (dut0.fifo0.full !== 1'b1 && !scan_over) begin
				@(posedge clk);
				#1;
			end
			assert (dut0.fifo0.full === 1'b1) else begin
				other_errors++;
				$display("output FIFO never filled in entry %0d", e);
			end
		end
		while (idx < total) begin
			@(posedge clk);
			#1;
			rden = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (empty === 1'b0) begin
				want = exp_moves[e][idx % counts[e]];
				assert (fifo_out === want) else begin
					value_errors++;
					$display("ERROR fifo_out expected %h actual %h (entry %0d move %0d)",
						want, fifo_out, e, idx);
				end
				rden = 1'b1;
				idx++;
				gap = $urandom % 4;
			end else if (scan_over) begin
				missing_errors += total - idx;
				$display("%0d expected moves never appeared in entry %0d", total - idx, e);
				idx = total;
			end
		end
		@(posedge clk);
		#1;
		rden = 1'b0;
		while (!scan_over) begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);
		#1;
		while (empty === 1'b0) begin
			extra_errors++;
			$display("unexpected extra move %h in entry %0d", fifo_out, e);
			rden = 1'b1;
			@(posedge clk);
			#1;
			rden = 1'b0;
		end
		check_flag("done", done, 1'b1);
	endtask

	initial begin
		int chk_fails;
		start = 1'b0;
		bstate = '0;
		side = 1'b0;
		rden = 1'b0;
		value_errors = 0;
		missing_errors = 0;
		extra_errors = 0;
		other_errors = 0;
		scan_over = 1'b0;
		table_ready = 1'b0;
		void'($urandom(65));
		build_table();
		table_ready = 1'b1;
		while (reset !== 1'b0) begin
			@(posedge clk);
		end
		#1;
		// idle after reset, nothing comes out
		repeat (20) begin
			check_flag("done", done, 1'b0);
			check_flag("empty", empty, 1'b1);
			@(posedge clk);
			#1;
		end
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			scan_over = 1'b0;
			fork
				run_scans(e);
				read_moves(e);
			join
		end
		chk_fails = dut0.ctrl0.ctrl_chk0.fails + dut0.ser0.ser_chk0.fails;
		$display("errors: value %0d, missing %0d, extra %0d, other %0d, assertion %0d",
			value_errors, missing_errors, extra_errors, other_errors, chk_fails);
		if (value_errors + missing_errors + extra_errors + other_errors + chk_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog sized from the scan passes in the table
	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = 64;
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			limit += passes[e] * CYCLES_PER_PASS;
		end
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, the run did not finish", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule
